/* Bender.yml */
package:
  name: lcd_video

sources:
  - common/lcd_timing_pkg.sv
  - common/lcd_color_pkg.sv
  - lcd/lcd_mode_sync.sv
  - lcd/line_buffer.sv
  - lcd/scan_timing.sv
  - lcd/pixel_palette.sv
  - source/lcd_video.sv
  - target: simulation
    files:
      - sim/lcd_clock_gen.sv
      - sim/tb_lcd_video.sv

/* common/lcd_color_pkg.sv */
// --------------------
// shade and colour types, palette tables indexed by shade
// shade 0 is the lightest entry in both tables
// --------------------
package lcd_color_pkg;

	// 2-bit controller shade
	typedef logic [1:0] shade_t;

	// 6 bits per channel
	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb_t;

	// --------------------
	// greyscale table
	// --------------------
	// equal levels on all channels
	localparam rgb_t GREY_LUT [4] = '{
		'{6'd63, 6'd63, 6'd63},
		'{6'd42, 6'd42, 6'd42},
		'{6'd24, 6'd24, 6'd24},
		'{6'd0,  6'd0,  6'd0}
	};

	// --------------------
	// yellow-green tint table
	// --------------------
	// light olive down to near black green
	localparam rgb_t TINT_LUT [4] = '{
		'{6'd39, 6'd47, 6'd4},
		'{6'd32, 6'd40, 6'd2},
		'{6'd12, 6'd25, 6'd12},
		'{6'd7,  6'd4,  6'd4}
	};

	// table pick and lookup in one place
	function automatic rgb_t lut_lookup(input logic tint, input shade_t shade);
		rgb_t res;
		if (tint) begin
			res = TINT_LUT[shade];
		end else begin
			res = GREY_LUT[shade];
		end
		return res;
	endfunction

endpackage

/* common/lcd_timing_pkg.sv */
// --------------------
// controller mode encoding and raster timing defaults
// defaults give a 228 x 616 raster with a 160-pixel visible line
// --------------------
package lcd_timing_pkg;

	// controller modes as reported on the mode pins
	typedef enum logic [1:0] {
		MODE_HBLANK   = 2'b00,
		MODE_VBLANK   = 2'b01,
		MODE_OAM      = 2'b10,
		MODE_OAM_VRAM = 2'b11
	} lcd_mode_e;

	// --------------------
	// horizontal segments, in pixels
	// --------------------
	localparam int unsigned H_VISIBLE_DEF = 160;
	localparam int unsigned H_FP_DEF      = 24;
	localparam int unsigned H_SYNC_DEF    = 20;
	localparam int unsigned H_BP_DEF      = 24;

	// --------------------
	// vertical segments, in lines
	// --------------------
	localparam int unsigned V_VISIBLE_DEF = 576;
	localparam int unsigned V_FP_DEF      = 2;
	localparam int unsigned V_SYNC_DEF    = 2;
	localparam int unsigned V_BP_DEF      = 36;

	// lines before wrap that v_cnt lands on when vblank ends
	// covers the delay of the scan doubler
	localparam int unsigned VSYNC_ALIGN_OFFSET = 4;

	// pixel index within one stored line
	typedef logic [7:0] line_addr_t;

	// raster position as seen by the line buffer and the palette
	typedef struct packed {
		logic       visible;
		line_addr_t rd_addr;
	} scan_pos_t;

endpackage

/* files.f */
common/lcd_timing_pkg.sv
common/lcd_color_pkg.sv
lcd/lcd_mode_sync.sv
lcd/line_buffer.sv
lcd/scan_timing.sv
lcd/pixel_palette.sv
source/lcd_video.sv
sim/lcd_clock_gen.sv
sim/tb_lcd_video.sv

/* lcd/lcd_mode_sync.sv */
// --------------------
// mode is sampled on pclk, so it must already be stable in that domain
// each pulse lasts one cycle, one cycle after the sampling edge
// --------------------
module lcd_mode_sync (
	input  logic                     pclk,
	input  logic                     rst_n,
	input  lcd_timing_pkg::lcd_mode_e mode,
	output logic                     line_start,
	output logic                     hblank_end,
	output logic                     vblank_end
);

	import lcd_timing_pkg::*;

	// mode seen at the previous edge
	lcd_mode_e mode_q;

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			mode_q     <= MODE_HBLANK;
			line_start <= 1'b0;
			hblank_end <= 1'b0;
			vblank_end <= 1'b0;
		end else begin
			mode_q <= mode;
			// leaving hblank toward any mode
			line_start <= (mode_q == MODE_HBLANK) && (mode != MODE_HBLANK);
			// hblank straight into oam search
			hblank_end <= (mode_q == MODE_HBLANK) && (mode == MODE_OAM);
			// any exit from vblank
			vblank_end <= (mode_q == MODE_VBLANK) && (mode != MODE_VBLANK);
		end
	end

	// --------------------
	// checks
	// --------------------
	// horizontal realign only ever comes with a buffer swap
	a_hblank_has_line_start: assert property (
		@(posedge pclk) disable iff (!rst_n)
		hblank_end |-> line_start
	);

endmodule

/* lcd/line_buffer.sv */
// --------------------
// 2 x 256 shades, one half written while the other is read
// pixels beyond 256 in a line overwrite from the wrapped pointer
// --------------------
module line_buffer (
	input  logic                     pclk,
	input  logic                     rst_n,
	input  logic                     pix_en,
	input  logic                     line_start,
	input  lcd_color_pkg::shade_t    pix,
	input  lcd_timing_pkg::scan_pos_t scan_pos,
	output lcd_color_pkg::shade_t    rd_pix
);

	import lcd_timing_pkg::*;
	import lcd_color_pkg::*;

	// --------------------
	// storage and write side
	// --------------------
	// toggle picks the write half, the raster reads the other
	shade_t     mem [512];
	line_addr_t wr_ptr;
	logic       toggle;

	// write pointer and half select
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			toggle <= 1'b0;
		end else if (line_start) begin
			// new controller line
			// restart at pixel 0 of the other half
			wr_ptr <= '0;
			toggle <= ~toggle;
		end else if (pix_en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// shade lands at the edge where pix_en is seen
	always_ff @(posedge pclk) begin
		if (pix_en) begin
			mem[{toggle, wr_ptr}] <= pix;
		end
	end

	// --------------------
	// read side
	// --------------------
	// same stored line is replayed on every raster line until the next swap
	// value holds outside the visible area
	always_ff @(posedge pclk) begin
		if (scan_pos.visible) begin
			rd_pix <= mem[{~toggle, scan_pos.rd_addr}];
		end
	end

	// --------------------
	// checks
	// --------------------
	// controller never shifts a pixel out during the mode change
	a_no_pix_on_swap: assert property (
		@(posedge pclk) disable iff (!rst_n)
		!(pix_en && line_start)
	);

endmodule

/* lcd/pixel_palette.sv */
// --------------------
// rgb follows rd_pix by one cycle, 0 outside the visible area
// on low shows shade 0 on every visible pixel
// --------------------
module pixel_palette (
	input  logic                  pclk,
	input  logic                  rst_n,
	input  logic                  tint,
	input  logic                  inv,
	input  logic                  on,
	input  lcd_color_pkg::shade_t rd_pix,
	input  logic                  visible,
	output lcd_color_pkg::rgb_t   rgb
);

	import lcd_color_pkg::*;

	// visible lined up with the registered shade
	logic   vis_q;
	shade_t shade_sel;
	rgb_t   lut_out;

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			vis_q <= 1'b0;
		end else begin
			vis_q <= visible;
		end
	end

	// --------------------
	// shade select
	// --------------------
	// display off forces the lightest shade
	// inversion flips both bits
	always_comb begin
		if (on) begin
			shade_sel = rd_pix ^ {2{inv}};
		end else begin
			shade_sel = '0;
		end
	end

	// grey or yellow-green table
	assign lut_out = lut_lookup(tint, shade_sel);

	// --------------------
	// output register
	// --------------------
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			rgb <= '0;
		end else if (vis_q) begin
			rgb <= lut_out;
		end else begin
			// blanked
			rgb <= '0;
		end
	end

endmodule

/* lcd/scan_timing.sv */
// --------------------
// free-running raster, phase locked to controller mode changes
// hs is active low, vs active high, both aligned with the counters
// --------------------
module scan_timing #(
	parameter int unsigned H_VISIBLE = lcd_timing_pkg::H_VISIBLE_DEF,
	parameter int unsigned H_FP      = lcd_timing_pkg::H_FP_DEF,
	parameter int unsigned H_SYNC    = lcd_timing_pkg::H_SYNC_DEF,
	parameter int unsigned H_BP      = lcd_timing_pkg::H_BP_DEF,
	parameter int unsigned V_VISIBLE = lcd_timing_pkg::V_VISIBLE_DEF,
	parameter int unsigned V_FP      = lcd_timing_pkg::V_FP_DEF,
	parameter int unsigned V_SYNC    = lcd_timing_pkg::V_SYNC_DEF,
	parameter int unsigned V_BP      = lcd_timing_pkg::V_BP_DEF
) (
	input  logic                      pclk,
	input  logic                      rst_n,
	input  logic                      hblank_end,
	input  logic                      vblank_end,
	output logic                      hs,
	output logic                      vs,
	output lcd_timing_pkg::scan_pos_t scan_pos
);

	import lcd_timing_pkg::*;

	// --------------------
	// derived timing
	// --------------------
	localparam int unsigned H_TOTAL    = H_VISIBLE + H_FP + H_SYNC + H_BP;
	localparam int unsigned V_TOTAL    = V_VISIBLE + V_FP + V_SYNC + V_BP;
	localparam int unsigned H_SYNC_ON  = H_VISIBLE + H_FP;
	localparam int unsigned H_SYNC_OFF = H_SYNC_ON + H_SYNC;
	localparam int unsigned V_SYNC_ON  = V_VISIBLE + V_FP;
	localparam int unsigned V_SYNC_OFF = V_SYNC_ON + V_SYNC;
	localparam int unsigned V_ALIGN    = V_TOTAL - VSYNC_ALIGN_OFFSET;
	localparam int unsigned H_W        = $clog2(H_TOTAL);
	localparam int unsigned V_W        = $clog2(V_TOTAL);

	logic [H_W-1:0] h_cnt;
	logic [H_W-1:0] h_next;
	logic [V_W-1:0] v_cnt;
	logic [V_W-1:0] v_next;
	logic           h_wrap;
	logic           vblank_pend;
	logic           visible;

	assign h_wrap = (h_cnt == H_W'(H_TOTAL - 1));

	// next horizontal count
	// end of hblank pulls the line start in
	always_comb begin
		if (hblank_end || h_wrap) begin
			h_next = '0;
		end else begin
			h_next = h_cnt + 1'b1;
		end
	end

	// next vertical count, only moves at h wrap
	// pending vblank end overrides the normal step
	always_comb begin
		v_next = v_cnt;
		if (h_wrap) begin
			if (vblank_pend || vblank_end) begin
				v_next = V_W'(V_ALIGN);
			end else if (v_cnt == V_W'(V_TOTAL - 1)) begin
				v_next = '0;
			end else begin
				v_next = v_cnt + 1'b1;
			end
		end
	end

	// --------------------
	// counters and sync
	// --------------------
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			h_cnt       <= '0;
			v_cnt       <= '0;
			vblank_pend <= 1'b0;
			hs          <= 1'b1;
			vs          <= 1'b0;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			// hold vblank end until the line boundary
			if (h_wrap) begin
				vblank_pend <= 1'b0;
			end else if (vblank_end) begin
				vblank_pend <= 1'b1;
			end
			// syncs follow the counter values they will sit next to
			hs <= !((h_next >= H_SYNC_ON) && (h_next < H_SYNC_OFF));
			vs <= (v_next >= V_SYNC_ON) && (v_next < V_SYNC_OFF);
		end
	end

	// --------------------
	// read position
	// --------------------
	assign visible = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);

	always_comb begin
		scan_pos.visible = visible;
		// pixel index tracks h_cnt across the visible part
		scan_pos.rd_addr = visible ? line_addr_t'(h_cnt) : '0;
	end

	// horizontal count never leaves the line
	a_h_in_range: assert property (
		@(posedge pclk) disable iff (!rst_n)
		h_cnt < H_TOTAL
	);

endmodule

/* sim/lcd_clock_gen.sv */
// --------------------
// free-running pclk, rst_n low for the first RESET_CYCLES edges
// release comes 1 ns after an edge, like the other inputs
// --------------------
module lcd_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic pclk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		pclk = 1'b0;
		forever #(PERIOD_NS / 2) pclk = ~pclk;
	end

	// synchronous reset, held over RESET_CYCLES rising edges
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge pclk);
		#1;
		rst_n = 1'b1;
	end

endmodule

/* sim/tb_lcd_video.sv */
// --------------------
// directed tests on a reduced 28 x 16 raster
// inputs change 1 ns after pclk rises, outputs are sampled on the falling edge
// --------------------
module tb_lcd_video;

	timeunit 1ns;
	timeprecision 100ps;

	import lcd_timing_pkg::*;
	import lcd_color_pkg::*;

	// --------------------
	// reduced timing
	// --------------------
	localparam int H_VIS   = 16;
	localparam int H_FP    = 4;
	localparam int H_SYN   = 4;
	localparam int H_BP    = 4;
	localparam int V_VIS   = 8;
	localparam int V_FP    = 2;
	localparam int V_SYN   = 2;
	localparam int V_BP    = 4;
	localparam int H_TOTAL = H_VIS + H_FP + H_SYN + H_BP;
	localparam int V_TOTAL = V_VIS + V_FP + V_SYN + V_BP;
	// line that the vertical count lands on after vblank ends
	localparam int V_ALIGN = V_TOTAL - VSYNC_ALIGN_OFFSET;
	localparam int CLK_NS      = 8;
	localparam int DRIVE_DLY   = 1;
	localparam int FRAME_NS    = H_TOTAL * V_TOTAL * CLK_NS;
	localparam int WATCHDOG_NS = 10 * FRAME_NS;
	// last sample of a frame check, one line past the last visible one
	localparam int LAST_J = 2 + H_TOTAL * (1 + VSYNC_ALIGN_OFFSET + V_VIS) + 1;

	logic      pclk;
	logic      rst_n;
	lcd_mode_e mode;
	logic      pix_en;
	shade_t    pix;
	logic      tint;
	logic      inv;
	logic      on;
	logic      hs;
	logic      vs;
	rgb_t      rgb;

	integer seed = 32'hd7c958b0;
	int     errors = 0;
	int     checks = 0;
	shade_t line_shades [H_VIS];

	lcd_clock_gen #(
		.PERIOD_NS    (CLK_NS),
		.RESET_CYCLES (2)
	) clock_gen_i (
		.pclk  (pclk),
		.rst_n (rst_n)
	);

	lcd_video #(
		.H_VISIBLE (H_VIS),
		.H_FP      (H_FP),
		.H_SYNC    (H_SYN),
		.H_BP      (H_BP),
		.V_VISIBLE (V_VIS),
		.V_FP      (V_FP),
		.V_SYNC    (V_SYN),
		.V_BP      (V_BP)
	) lcd_video_i (
		.pclk   (pclk),
		.rst_n  (rst_n),
		.mode   (mode),
		.pix_en (pix_en),
		.pix    (pix),
		.tint   (tint),
		.inv    (inv),
		.on     (on),
		.hs     (hs),
		.vs     (vs),
		.rgb    (rgb)
	);

	// --------------------
	// compare tasks
	// --------------------
	task automatic compare_rgb(input rgb_t got, input rgb_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0d ns: %s rgb got %0d/%0d/%0d expected %0d/%0d/%0d",
				$time, what, got.r, got.g, got.b, exp.r, exp.g, exp.b);
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0d ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("MISMATCH at %0d ns: %s got %0d cycles expected %0d",
				$time, what, got, exp);
		end
	endtask

	// palette rules: off shows shade 0, inv flips both bits, tint picks the table
	function automatic rgb_t expected_rgb(input logic t, input logic i, input logic o,
		input shade_t s);
		shade_t idx;
		idx = s;
		if (!o) begin
			idx = 2'd0;
		end else if (i) begin
			idx = s ^ 2'b11;
		end
		if (t) begin
			return TINT_LUT[idx];
		end else begin
			return GREY_LUT[idx];
		end
	endfunction

	// --------------------
	// stimulus helpers
	// --------------------
	task automatic drive_mode(input lcd_mode_e m);
		@(posedge pclk);
		#DRIVE_DLY;
		mode = m;
	endtask

	// falling edges until the sync goes to level, counting from the call
	task automatic count_to_edge(input logic use_vs, input logic level, output int cycles);
		logic prev;
		logic cur;
		logic done;
		cycles = 0;
		prev = use_vs ? vs : hs;
		do begin
			@(negedge pclk);
			cycles++;
			cur = use_vs ? vs : hs;
			done = (prev != level) && (cur == level);
			prev = cur;
		end while (!done);
	endtask

	// one controller line of random shades
	task automatic load_line();
		for (int k = 0; k < H_VIS; k++) begin
			line_shades[k] = shade_t'($random(seed));
			@(posedge pclk);
			#DRIVE_DLY;
			pix_en = 1'b1;
			pix = line_shades[k];
		end
		@(posedge pclk);
		#DRIVE_DLY;
		pix_en = 1'b0;
	endtask

	// hblank to oam sets h_cnt to 0 two edges on, then a vblank exit
	// returns right after the hblank drive
	task automatic align_raster();
		drive_mode(MODE_OAM);
		drive_mode(MODE_VBLANK);
		drive_mode(MODE_HBLANK);
	endtask

	// walks the aligned raster and checks every rgb sample
	task automatic check_frame(input logic t, input logic i, input logic o, input string what);
		int   h;
		int   ln;
		int   v;
		rgb_t exp;
		for (int j = 0; j <= LAST_J; j++) begin
			@(negedge pclk);
			// sample j shows the position of edge j, h_cnt was 0 at edge 2
			// first line still has the old v_cnt
			if (j >= 2 + H_TOTAL) begin
				h = (j - 2) % H_TOTAL;
				ln = (j - 2) / H_TOTAL;
				v = (V_ALIGN + ln - 1) % V_TOTAL;
				if ((h < H_VIS) && (v < V_VIS)) begin
					exp = expected_rgb(t, i, o, line_shades[h]);
				end else begin
					exp = '0;
				end
				compare_rgb(rgb, exp, $sformatf("%s line %0d pixel %0d", what, v, h));
			end
		end
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic test_reset_state();
		// two reset edges and the first running edge
		repeat (3) begin
			@(negedge pclk);
			compare_bit(hs, 1'b1, "hs after reset");
			compare_bit(vs, 1'b0, "vs after reset");
			compare_rgb(rgb, '0, "after reset");
		end
	endtask

	task automatic test_hsync();
		int n;
		int n_low;
		int n_high;
		count_to_edge(1'b0, 1'b0, n);
		count_to_edge(1'b0, 1'b1, n_low);
		count_to_edge(1'b0, 1'b0, n_high);
		compare_count(n_low, H_SYN, "hs low time");
		compare_count(n_low + n_high, H_TOTAL, "hs period");
		// mode register and pulse register come before the realigned count
		drive_mode(MODE_OAM);
		count_to_edge(1'b0, 1'b0, n);
		compare_count(n, 2 + H_VIS + H_FP + 1, "hs fall after hblank end");
		drive_mode(MODE_HBLANK);
	endtask

	task automatic test_vsync();
		int n;
		int n_high;
		int n_low;
		count_to_edge(1'b1, 1'b1, n);
		count_to_edge(1'b1, 1'b0, n_high);
		count_to_edge(1'b1, 1'b1, n_low);
		compare_count(n_high, V_SYN * H_TOTAL, "vs high time");
		compare_count(n_high + n_low, V_TOTAL * H_TOTAL, "vs period");
		// rest of the first line, offset lines to wrap, then visible and porch
		align_raster();
		count_to_edge(1'b1, 1'b1, n);
		compare_count(n, 1 + H_TOTAL * (1 + VSYNC_ALIGN_OFFSET + V_VIS + V_FP),
			"vs rise after vblank end");
	endtask

	task automatic test_line_transfer();
		load_line();
		align_raster();
		check_frame(1'b0, 1'b0, 1'b1, "grey");
	endtask

	task automatic test_palette();
		@(posedge pclk);
		#DRIVE_DLY;
		tint = 1'b1;
		load_line();
		align_raster();
		check_frame(1'b1, 1'b0, 1'b1, "tint");
		// inversion on greyscale
		@(posedge pclk);
		#DRIVE_DLY;
		tint = 1'b0;
		inv = 1'b1;
		load_line();
		align_raster();
		check_frame(1'b0, 1'b1, 1'b1, "inv");
		// display off
		@(posedge pclk);
		#DRIVE_DLY;
		inv = 1'b0;
		on = 1'b0;
		load_line();
		align_raster();
		check_frame(1'b0, 1'b0, 1'b0, "off");
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("%-16s ok", name);
		end else begin
			$display("%-16s %0d errors", name, errors - errs_before);
		end
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		int e;
		mode = MODE_HBLANK;
		pix_en = 1'b0;
		pix = '0;
		tint = 1'b0;
		inv = 1'b0;
		on = 1'b1;
		e = errors;
		test_reset_state();
		report_test("reset_state", e);
		e = errors;
		test_hsync();
		report_test("hsync", e);
		e = errors;
		test_vsync();
		report_test("vsync", e);
		e = errors;
		test_line_transfer();
		report_test("line_transfer", e);
		e = errors;
		test_palette();
		report_test("palette", e);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// ten frames of the reduced raster
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run still going after %0d ns", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

endmodule

/* source/lcd_video.sv */
// --------------------
// LCD pixel stream to scan-doubled raster on one pclk
// pix_en must be a single-cycle strobe, inputs synchronous to pclk
// --------------------
module lcd_video #(
	parameter int unsigned H_VISIBLE = lcd_timing_pkg::H_VISIBLE_DEF,
	parameter int unsigned H_FP      = lcd_timing_pkg::H_FP_DEF,
	parameter int unsigned H_SYNC    = lcd_timing_pkg::H_SYNC_DEF,
	parameter int unsigned H_BP      = lcd_timing_pkg::H_BP_DEF,
	parameter int unsigned V_VISIBLE = lcd_timing_pkg::V_VISIBLE_DEF,
	parameter int unsigned V_FP      = lcd_timing_pkg::V_FP_DEF,
	parameter int unsigned V_SYNC    = lcd_timing_pkg::V_SYNC_DEF,
	parameter int unsigned V_BP      = lcd_timing_pkg::V_BP_DEF
) (
	input  logic                      pclk,
	input  logic                      rst_n,
	input  lcd_timing_pkg::lcd_mode_e mode,
	input  logic                      pix_en,
	input  lcd_color_pkg::shade_t     pix,
	input  logic                      tint,
	input  logic                      inv,
	input  logic                      on,
	output logic                      hs,
	output logic                      vs,
	output lcd_color_pkg::rgb_t       rgb
);

	import lcd_timing_pkg::*;
	import lcd_color_pkg::*;

	// mode transition pulses
	logic      line_start;
	logic      hblank_end;
	logic      vblank_end;
	// raster read side
	scan_pos_t scan_pos;
	shade_t    rd_pix;

	// --------------------
	// controller side
	// --------------------
	lcd_mode_sync lcd_mode_sync_i (
		.pclk       (pclk),
		.rst_n      (rst_n),
		.mode       (mode),
		.line_start (line_start),
		.hblank_end (hblank_end),
		.vblank_end (vblank_end)
	);

	line_buffer line_buffer_i (
		.pclk       (pclk),
		.rst_n      (rst_n),
		.pix_en     (pix_en),
		.line_start (line_start),
		.pix        (pix),
		.scan_pos   (scan_pos),
		.rd_pix     (rd_pix)
	);

	// --------------------
	// raster side
	// --------------------
	scan_timing #(
		.H_VISIBLE (H_VISIBLE),
		.H_FP      (H_FP),
		.H_SYNC    (H_SYNC),
		.H_BP      (H_BP),
		.V_VISIBLE (V_VISIBLE),
		.V_FP      (V_FP),
		.V_SYNC    (V_SYNC),
		.V_BP      (V_BP)
	) scan_timing_i (
		.pclk       (pclk),
		.rst_n      (rst_n),
		.hblank_end (hblank_end),
		.vblank_end (vblank_end),
		.hs         (hs),
		.vs         (vs),
		.scan_pos   (scan_pos)
	);

	// visible to rgb is two cycles, buffer read then palette
	pixel_palette pixel_palette_i (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.tint    (tint),
		.inv     (inv),
		.on      (on),
		.rd_pix  (rd_pix),
		.visible (scan_pos.visible),
		.rgb     (rgb)
	);

endmodule
